//--- verilog/corePkg.sv
`default_nettype none

package corePkg;

    localparam int Xlen    = 32;
    localparam int RegIdxW = 5;
    localparam int NumRegs = 32;

    typedef logic [Xlen-1:0]    word_t;
    typedef logic [RegIdxW-1:0] regIdx_t;

    localparam logic [6:0] OpcodeOp    = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm = 7'b0010011;
    localparam logic [6:0] OpcodeLoad  = 7'b0000011;
    localparam logic [6:0] OpcodeStore = 7'b0100011;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluXor, AluOr, AluAnd,
        AluSlt, AluSltu, AluSll, AluSrl, AluSra
    } aluOp_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetchOut_t;

    typedef struct packed {
        aluOp_t  aluOp;
        logic    useImm;   // operand b from imm
        logic    isLoad;
        logic    isStore;
        logic    wrEn;
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        word_t   imm;
        word_t   pc;
        word_t   instr;
    } uop_t;

    typedef struct packed {
        logic    wrEn;
        regIdx_t rd;
        word_t   value;
        word_t   pc;
        word_t   instr;
    } wbReq_t;

    typedef struct packed {
        logic    valid;
        logic    wrEn;
        regIdx_t rd;
        word_t   value;
        word_t   pc;
        word_t   instr;
    } retire_t;

endpackage

`default_nettype wire

//--- verilog/memPkg.sv
`default_nettype none

package memPkg;

    localparam int AddrW      = 32;
    localparam int RowW       = 32;
    localparam int NumRows    = 1024;
    localparam int RowIdxW    = $clog2(NumRows);
    localparam int NumReaders = 2;
    localparam int PortW      = $clog2(NumReaders);

    // higher index wins arbitration
    localparam int FetchPort = 0;
    localparam int DataPort  = 1;

    localparam string MemInitFile = "tests/program.hex";

    typedef struct packed {
        logic             en;
        logic [AddrW-1:0] addr;
    } readReq_t;

    typedef struct packed {
        logic             en;
        logic [AddrW-1:0] addr;
        logic [RowW-1:0]  data;
    } writeReq_t;

endpackage

`default_nettype wire

//--- verilog/fetchUnit.sv
`default_nettype none

module fetchUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               startSig,
    output memPkg::readReq_t   rdReq,
    input  logic               rdFin,
    input  corePkg::word_t     rdData,
    output corePkg::fetchOut_t out,
    output logic               readyToSend,
    input  logic               nextReadyToRcv
);
    import corePkg::*;
    import memPkg::*;

    logic [AddrW-1:0] pc;
    logic             reqEn;

    // pc stays put while a read is outstanding
    assign rdReq = '{en: reqEn, addr: pc};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc          <= '0;
            reqEn       <= 1'b0;
            readyToSend <= 1'b0;
        end else begin
            if (rdFin) begin
                reqEn       <= 1'b0;
                readyToSend <= 1'b1;
            end else if (startSig && !reqEn && !readyToSend) begin
                reqEn <= 1'b1;   // one read in flight at most
            end
            if (readyToSend && nextReadyToRcv) begin
                readyToSend <= 1'b0;
                pc          <= pc + AddrW'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFin) begin
            out.instr <= rdData;
            out.pc    <= word_t'(pc);
        end
    end

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`default_nettype none

module decoder (
    input  logic               clk,
    input  logic               arstN,
    input  corePkg::fetchOut_t in,
    input  logic               prevReadyToSend,
    output logic               readyToRcv,
    output corePkg::uop_t      out,
    output logic               readyToSend,
    input  logic               nextReadyToRcv
);
    import corePkg::*;

    uop_t       dec;
    logic [6:0] opcode;
    logic       accept;

    function automatic aluOp_t aluSel(input logic [2:0] funct3, input logic alt,
                                      input logic isReg);
        case (funct3)
            3'b000:  return (alt && isReg) ? AluSub : AluAdd;  // no subi
            3'b001:  return AluSll;
            3'b010:  return AluSlt;
            3'b011:  return AluSltu;
            3'b100:  return AluXor;
            3'b101:  return alt ? AluSra : AluSrl;
            3'b110:  return AluOr;
            default: return AluAnd;
        endcase
    endfunction

    assign opcode = in.instr[6:0];

    always_comb begin
        dec.rd      = in.instr[11:7];
        dec.rs1     = in.instr[19:15];
        dec.rs2     = in.instr[24:20];
        dec.pc      = in.pc;
        dec.instr   = in.instr;
        dec.imm     = {{20{in.instr[31]}}, in.instr[31:20]};
        dec.aluOp   = AluAdd;
        dec.useImm  = 1'b0;
        dec.isLoad  = 1'b0;
        dec.isStore = 1'b0;
        dec.wrEn    = 1'b0;
        case (opcode)
            OpcodeOp: begin
                dec.aluOp = aluSel(in.instr[14:12], in.instr[30], 1'b1);
                dec.wrEn  = 1'b1;
            end
            OpcodeOpImm: begin
                dec.aluOp  = aluSel(in.instr[14:12], in.instr[30], 1'b0);
                dec.useImm = 1'b1;
                dec.wrEn   = 1'b1;
            end
            OpcodeLoad: begin
                dec.useImm = 1'b1;
                dec.isLoad = 1'b1;
                dec.wrEn   = 1'b1;
            end
            OpcodeStore: begin
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
                dec.imm     = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
            end
            default: ;   // retires as a no-op
        endcase
        if (dec.rd == '0) begin
            dec.wrEn = 1'b0;
        end
    end

    assign readyToRcv = !readyToSend || nextReadyToRcv;
    assign accept     = prevReadyToSend && readyToRcv;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyToSend <= 1'b0;
        end else if (accept) begin
            readyToSend <= 1'b1;
        end else if (nextReadyToRcv) begin
            readyToSend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= dec;
        end
    end

endmodule

`default_nettype wire

//--- verilog/execUnit.sv
`default_nettype none

module execUnit (
    input  logic              clk,
    input  logic              arstN,
    input  corePkg::uop_t     in,
    input  logic              prevReadyToSend,
    output logic              readyToRcv,
    output corePkg::regIdx_t  rfIdxA,
    output corePkg::regIdx_t  rfIdxB,
    input  corePkg::word_t    rfDataA,
    input  corePkg::word_t    rfDataB,
    input  corePkg::regIdx_t  bpIdx,
    input  corePkg::word_t    bpVal,
    input  logic              bpValid,
    output memPkg::readReq_t  rdReq,
    input  logic              rdFin,
    input  corePkg::word_t    rdData,
    output memPkg::writeReq_t wrReq,
    output corePkg::wbReq_t   out,
    output logic              readyToSend
);
    import corePkg::*;
    import memPkg::*;

    uop_t  cur;
    logic  busy;
    logic  accept;
    word_t srcA;
    word_t srcB;
    word_t opB;
    word_t aluRes;

    assign rfIdxA = cur.rs1;
    assign rfIdxB = cur.rs2;

    // write-back result not yet in the register file
    assign srcA = (bpValid && bpIdx == cur.rs1) ? bpVal : rfDataA;
    assign srcB = (bpValid && bpIdx == cur.rs2) ? bpVal : rfDataB;
    assign opB  = cur.useImm ? cur.imm : srcB;

    always_comb begin
        case (cur.aluOp)
            AluAdd:  aluRes = srcA + opB;
            AluSub:  aluRes = srcA - opB;
            AluXor:  aluRes = srcA ^ opB;
            AluOr:   aluRes = srcA | opB;
            AluAnd:  aluRes = srcA & opB;
            AluSlt:  aluRes = word_t'($signed(srcA) < $signed(opB));
            AluSltu: aluRes = word_t'(srcA < opB);
            AluSll:  aluRes = srcA << opB[4:0];
            AluSrl:  aluRes = srcA >> opB[4:0];
            AluSra:  aluRes = word_t'($signed(srcA) >>> opB[4:0]);
            default: aluRes = srcA + opB;
        endcase
    end

    // address comes from the adder for loads and stores
    assign rdReq = '{en: busy && cur.isLoad, addr: AddrW'(aluRes)};
    assign wrReq = '{en: busy && cur.isStore, addr: AddrW'(aluRes), data: srcB};

    assign readyToSend = busy && (!cur.isLoad || rdFin);   // wb never stalls
    assign readyToRcv  = !busy || readyToSend;
    assign accept      = prevReadyToSend && readyToRcv;

    always_comb begin
        out.wrEn  = cur.wrEn;
        out.rd    = cur.rd;
        out.value = cur.isLoad ? rdData : aluRes;
        out.pc    = cur.pc;
        out.instr = cur.instr;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (readyToSend) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeBack.sv
`default_nettype none

module writeBack (
    input  logic             clk,
    input  logic             arstN,
    input  corePkg::wbReq_t  in,
    input  logic             prevReadyToSend,
    input  corePkg::regIdx_t rfIdxA,
    input  corePkg::regIdx_t rfIdxB,
    output corePkg::word_t   rfDataA,
    output corePkg::word_t   rfDataB,
    output corePkg::regIdx_t bpIdx,
    output corePkg::word_t   bpVal,
    output logic             bpValid,
    output corePkg::retire_t retire
);
    import corePkg::*;

    word_t  regFile [NumRegs];
    wbReq_t wbR;
    logic   wbValid;

    assign rfDataA = (rfIdxA == '0) ? '0 : regFile[rfIdxA];
    assign rfDataB = (rfIdxB == '0) ? '0 : regFile[rfIdxB];

    assign bpIdx   = wbR.rd;
    assign bpVal   = wbR.value;
    assign bpValid = wbValid && wbR.wrEn;   // decoder already cleared rd 0

    always_comb begin
        retire.valid = wbValid;
        retire.wrEn  = wbR.wrEn;
        retire.rd    = wbR.rd;
        retire.value = wbR.value;
        retire.pc    = wbR.pc;
        retire.instr = wbR.instr;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= prevReadyToSend;   // always ready
        end
    end

    always_ff @(posedge clk) begin
        if (prevReadyToSend) begin
            wbR <= in;
        end
        if (bpValid) begin
            regFile[wbR.rd] <= wbR.value;
        end
    end

endmodule

`default_nettype wire

//--- verilog/storageMgmt.sv
`default_nettype none

module storageMgmt (
    input  logic                          clk,
    input  logic                          arstN,
    input  memPkg::readReq_t              rdReq [memPkg::NumReaders],
    input  memPkg::writeReq_t             wrReq,
    output logic [memPkg::NumReaders-1:0] rdFin,
    output corePkg::word_t                poolData
);
    import memPkg::*;

    logic [RowW-1:0]  mem [NumRows];
    logic             grantValid;
    logic [PortW-1:0] grantPort;

    initial begin
        $readmemh(MemInitFile, mem);
    end

    // a port in its finish cycle is already served
    always_comb begin
        grantValid = 1'b0;
        grantPort  = '0;
        for (int i = 0; i < NumReaders; i++) begin
            if (rdReq[i].en && !rdFin[i]) begin
                grantValid = 1'b1;
                grantPort  = PortW'(i);   // later index overrides
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdFin <= '0;
        end else begin
            rdFin <= '0;
            if (grantValid) begin
                rdFin[grantPort] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantValid) begin
            poolData <= mem[rdReq[grantPort].addr[RowIdxW+1:2]];
        end
        if (wrReq.en) begin
            mem[wrReq.addr[RowIdxW+1:2]] <= wrReq.data;   // word rows only
        end
    end

endmodule

`default_nettype wire

//--- verilog/core.sv
`default_nettype none

module core (
    input  logic             clk,
    input  logic             arstN,
    input  logic             startSig,
    output corePkg::retire_t retire
);
    import corePkg::*;
    import memPkg::*;

    fetchOut_t             fetchOut;
    logic                  fetchRts;
    uop_t                  uop;
    logic                  decRtr;
    logic                  decRts;
    wbReq_t                wbReq;
    logic                  execRtr;
    logic                  execRts;
    regIdx_t               rfIdxA;
    regIdx_t               rfIdxB;
    word_t                 rfDataA;
    word_t                 rfDataB;
    regIdx_t               bpIdx;
    word_t                 bpVal;
    logic                  bpValid;
    readReq_t              rdReq [NumReaders];
    writeReq_t             wrReq;
    logic [NumReaders-1:0] rdFin;
    word_t                 poolData;   // shared by both readers

    fetchUnit fetch_i (
        .clk, .arstN, .startSig,
        .rdReq(rdReq[FetchPort]), .rdFin(rdFin[FetchPort]), .rdData(poolData),
        .out(fetchOut), .readyToSend(fetchRts), .nextReadyToRcv(decRtr)
    );

    decoder decode_i (
        .clk, .arstN,
        .in(fetchOut), .prevReadyToSend(fetchRts), .readyToRcv(decRtr),
        .out(uop), .readyToSend(decRts), .nextReadyToRcv(execRtr)
    );

    execUnit exec_i (
        .clk, .arstN,
        .in(uop), .prevReadyToSend(decRts), .readyToRcv(execRtr),
        .rfIdxA, .rfIdxB, .rfDataA, .rfDataB,
        .bpIdx, .bpVal, .bpValid,
        .rdReq(rdReq[DataPort]), .rdFin(rdFin[DataPort]), .rdData(poolData),
        .wrReq, .out(wbReq), .readyToSend(execRts)
    );

    writeBack wb_i (
        .clk, .arstN,
        .in(wbReq), .prevReadyToSend(execRts),
        .rfIdxA, .rfIdxB, .rfDataA, .rfDataB,
        .bpIdx, .bpVal, .bpValid, .retire
    );

    storageMgmt mem_i (
        .clk, .arstN, .rdReq, .wrReq, .rdFin, .poolData
    );

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod  = 10;
    localparam int ResetCycles = 5;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        arstN = 1'b1;   // released between rising edges
    end

endmodule

`default_nettype wire

//--- tests/retire_checker.sv
`default_nettype none

module retireChecker (
    input logic                          clk,
    input logic                          arstN,
    input logic                          startSig,
    input corePkg::retire_t              retire,
    input memPkg::readReq_t              rdReq [memPkg::NumReaders],
    input logic [memPkg::NumReaders-1:0] rdFin
);
    timeunit 1ns;
    timeprecision 100ps;
    import memPkg::*;

    logic started;
    int   failCount = 0;   // read by the testbench

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            started <= 1'b0;
        end else if (startSig) begin
            started <= 1'b1;
        end
    end

    noRetireBeforeStart: assert property (@(posedge clk) disable iff (!arstN)
        !started |-> !retire.valid)
    else begin
        failCount++;
        $error("retire valid high before startSig was raised");
    end

    oneFinishPerCycle: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(rdFin))
    else begin
        failCount++;
        $error("more than one readFin high in the same cycle");
    end

    fetchFinRequested: assert property (@(posedge clk) disable iff (!arstN)
        rdFin[FetchPort] |-> rdReq[FetchPort].en)
    else begin
        failCount++;
        $error("fetch readFin without a fetch request");
    end

    dataFinRequested: assert property (@(posedge clk) disable iff (!arstN)
        rdFin[DataPort] |-> rdReq[DataPort].en)
    else begin
        failCount++;
        $error("data readFin without a data request");
    end

    // requester keeps en and addr until its finish pulse
    fetchReqHeld: assert property (@(posedge clk) disable iff (!arstN)
        rdReq[FetchPort].en && !rdFin[FetchPort]
        |=> rdReq[FetchPort].en && $stable(rdReq[FetchPort].addr))
    else begin
        failCount++;
        $error("fetch request dropped or changed before readFin");
    end

    dataReqHeld: assert property (@(posedge clk) disable iff (!arstN)
        rdReq[DataPort].en && !rdFin[DataPort]
        |=> rdReq[DataPort].en && $stable(rdReq[DataPort].addr))
    else begin
        failCount++;
        $error("data request dropped or changed before readFin");
    end

endmodule

bind core retireChecker chk_i (
    .clk, .arstN, .startSig, .retire, .rdReq, .rdFin
);

`default_nettype wire

//--- tests/coreTb.sv
`default_nettype none

module coreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;
    import memPkg::*;

    localparam int NumRetires     = 40;
    localparam int CyclesPerInsn  = 12;
    localparam int ResetCycles    = 5;
    localparam int MinStartDelay  = 10;
    localparam int MaxStartJitter = 8;
    localparam int WatchdogCycles = NumRetires * CyclesPerInsn + ResetCycles
                                    + MinStartDelay + MaxStartJitter;

    logic    clk;
    logic    arstN;
    logic    startSig;
    retire_t retire;

    word_t regs [NumRegs];   // shadow architectural state
    word_t shadowMem [NumRows];
    word_t expPc;
    int    retireCount;

    clockGen clkGen_i (.clk, .arstN);

    core dut_i (.clk, .arstN, .startSig, .retire);

    task automatic failRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic mismatch(input string sigName, input word_t expected, input word_t actual);
        $display("Mismatch at %0t ns: %s expected %h actual %h",
                 $time, sigName, expected, actual);
        failRun();
    endtask

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic int rowOf(input word_t addr);
        return int'((addr >> 2) % NumRows);   // wraps at array depth
    endfunction

    function automatic logic writesRd(input word_t instr);
        logic [6:0] opc;
        opc = instr[6:0];
        if (instr[11:7] == 5'd0) begin
            return 1'b0;
        end
        return opc == OpcodeOp || opc == OpcodeOpImm || opc == OpcodeLoad;
    endfunction

    // b is rs2 or the sign-extended immediate
    function automatic word_t aluResult(input word_t instr, input word_t a, input word_t b,
                                        input logic isReg);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (instr[14:12])
            3'd0:    return (isReg && instr[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return word_t'((a[31] != b[31]) ? a[31] : (a < b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return instr[30] ? ((a >> sh) | fill) : (a >> sh);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkRetire();
        word_t instr;
        word_t a;
        word_t b;
        word_t expVal;
        logic  expWr;
        instr  = retire.instr;
        a      = regs[instr[19:15]];
        b      = regs[instr[24:20]];
        expWr  = writesRd(instr);
        expVal = '0;
        assert (retire.pc == expPc) else mismatch("retire.pc", expPc, retire.pc);
        assert (instr == shadowMem[rowOf(expPc)])
            else mismatch("retire.instr", shadowMem[rowOf(expPc)], instr);
        case (instr[6:0])
            OpcodeOp:    expVal = aluResult(instr, a, b, 1'b1);
            OpcodeOpImm: expVal = aluResult(instr, a, sext12(instr[31:20]), 1'b0);
            OpcodeLoad:  expVal = shadowMem[rowOf(a + sext12(instr[31:20]))];
            OpcodeStore: shadowMem[rowOf(a + sext12({instr[31:25], instr[11:7]}))] = b;
            default:     ;
        endcase
        assert (retire.wrEn == expWr)
            else mismatch("retire.wrEn", word_t'(expWr), word_t'(retire.wrEn));
        if (expWr) begin
            assert (retire.rd == instr[11:7])
                else mismatch("retire.rd", word_t'(instr[11:7]), word_t'(retire.rd));
            assert (retire.value == expVal) else mismatch("retire.value", expVal, retire.value);
            regs[instr[11:7]] = expVal;
        end
        expPc = expPc + 32'd4;
        retireCount++;
    endtask

    initial begin
        int startDelay;
        void'($urandom(32'h27911a0b));
        startDelay  = MinStartDelay + int'($urandom % MaxStartJitter);
        startSig    = 1'b0;
        expPc       = '0;
        retireCount = 0;
        for (int i = 0; i < NumRegs; i++) begin
            regs[i] = '0;
        end
        $readmemh(MemInitFile, shadowMem);
        @(posedge arstN);
        repeat (startDelay) @(posedge clk);
        startSig <= 1'b1;
    end

    always @(negedge clk) begin
        if (arstN && retire.valid) begin
            checkRetire();
        end
    end

    always @(negedge clk) begin
        if (dut_i.chk_i.failCount != 0) begin
            $display("Protocol assertion failed in retireChecker at %0t ns", $time);
            failRun();
        end
    end

    initial begin
        wait (retireCount == NumRetires);
        repeat (2) @(negedge clk);
        if (dut_i.chk_i.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("retireChecker reported %0d failures", dut_i.chk_i.failCount);
            failRun();
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: %0d of %0d instructions retired after %0d cycles",
                 retireCount, NumRetires, WatchdogCycles);
        failRun();
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/corePkg.sv
verilog/memPkg.sv
verilog/fetchUnit.sv
verilog/decoder.sv
verilog/execUnit.sv
verilog/writeBack.sv
verilog/storageMgmt.sv
verilog/core.sv
tests/clockGen.sv
tests/retire_checker.sv
tests/coreTb.sv

//--- run.sh
#!/bin/sh
# builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module coreTb \
    -f flist.f -o coreSim \
    && ./obj_dir/coreSim +verilator+error+limit+100 > sim.log 2>&1
grep -qs "Done: no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/program.hex
// rows 0..39: RV32I instruction words, four per line in program order
// row 512 (@200): data words read and written by the loads and stores
00500093 FFD00113 002081B3 40118233
001242B3 0022E333 001373B3 00122433
001234B3 008095B3 00825633 408256B3
0F06C713 00376793 7FF7F813 FFF6A893
FFF0B913 00481993 01C6DA13 40475A93
40000513 00A50533 00052B03 00452B83
017B0C33 01852423 00852C83 01352623
01552823 00C52D03 01052D83 41AD8E33
01C52A23 01452E83 00208033 123452B7
FFFE8F13 007F6FB3 01F030B3 001FC133
@200
12345678 0BADF00D 00000000 00000000
CAFEF00D 55AA55AA 00000000 00000000
